/* sdmac_consts.svh */
/*
 * Global width and depth constants for the SCSI-style DMA engine
 * Data, address and word count widths, default FIFO depth
 */
`ifndef SDMAC_CONSTS_SVH
`define SDMAC_CONSTS_SVH

// Bus data word, one full word per Wishbone cycle
`define SDMAC_DATA_W 32

// Byte address on the memory side
`define SDMAC_ADDR_W 32

// Programmed transfer length in words
`define SDMAC_CNT_W 16

// Words buffered between peripheral and engine
`define SDMAC_FIFO_DEPTH 8

`endif

/* dma_types_pkg.sv */
/*
 * Engine side types: state enum, decoded transition terms,
 * FIFO status flags and the peripheral push and pop ports
 */
`include "sdmac_consts.svh"

package dma_types_pkg;

  typedef enum logic [2:0] {
    S_IDLE       = 3'd0,
    S_FETCH      = 3'd1, // Read cycle in progress
    S_FILL_WAIT  = 3'd2, // FIFO full, no fetch allowed
    S_DRAIN_WAIT = 3'd3, // FIFO empty, nothing to store
    S_STORE      = 3'd4, // Write cycle in progress
    S_DONE       = 3'd5
  } cpu_state_t;

  typedef struct packed {
    logic start_fetch;
    logic start_store;
    logic fetch_done;
    logic store_done;
    logic wait_space;
    logic wait_data;
    logic finish;
    logic abort;
  } sm_terms_t;

  typedef struct packed {
    logic empty;
    logic full;
    logic one_left; // Single free slot remaining
  } fifo_stat_t;

  typedef struct packed {
    logic                     valid;
    logic [`SDMAC_DATA_W-1:0] data;
  } periph_push_t;

  typedef struct packed {
    logic                     valid;
    logic [`SDMAC_DATA_W-1:0] data;
  } periph_pop_t;

endpackage

/* wb_types_pkg.sv */
/*
 * Bus side types: cycle opcode enum, the request from the state
 * machine and the Wishbone classic master and slave signal bundles
 */
`include "sdmac_consts.svh"

package wb_types_pkg;

  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } bus_op_t;

  typedef struct packed {
    bus_op_t                  op;
    logic [`SDMAC_ADDR_W-1:0] adr;
    logic [`SDMAC_DATA_W-1:0] dat; // Store data, ignored on reads
  } bus_req_t;

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`SDMAC_ADDR_W-1:0] adr;
    logic [`SDMAC_DATA_W-1:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic                     ack;
    logic [`SDMAC_DATA_W-1:0] dat;
  } wb_s2m_t;

endpackage

/* dma_fifo.sv */
/*
 * Word FIFO between the peripheral and the DMA engine
 * Circular buffer, valid/ready on both ends, empty/full/one_left flags
 */
`timescale 1ns/1ps
`include "sdmac_consts.svh"

module dma_fifo import dma_types_pkg::*; #(
  parameter int DEPTH = `SDMAC_FIFO_DEPTH
) (
  input  logic         clk,
  input  logic         rst,
  input  periph_push_t push,
  output logic         push_ready,
  output periph_pop_t  pop,
  input  logic         pop_ready,
  output fifo_stat_t   stat
);

  localparam int DATA_W = `SDMAC_DATA_W;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = PTR_W + 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  assign push_ready = (count != FULL_CNT);
  assign do_push    = push.valid & push_ready;
  assign do_pop     = pop.valid & pop_ready;

  assign pop = '{valid: (count != '0), data: mem[rd_ptr]};

  assign stat.empty    = (count == '0);
  assign stat.full     = (count == FULL_CNT);
  assign stat.one_left = (count == FULL_CNT - 1'b1); // Next push fills it

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // Wrap for any depth
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push.data;
    end
  end

endmodule

/* wb_master.sv */
/*
 * Wishbone classic master, one cycle outstanding
 * Launches a cycle per request, holds the bus until ack,
 * then pulses cycle_done with the registered read data
 */
`timescale 1ns/1ps
`include "sdmac_consts.svh"

module wb_master import wb_types_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  bus_req_t                 req,
  output wb_m2s_t                  wb_o,
  input  wb_s2m_t                  wb_i,
  output logic                     cycle_done,
  output logic [`SDMAC_DATA_W-1:0] rd_dat
);

  localparam int DATA_W = `SDMAC_DATA_W;
  localparam int ADDR_W = `SDMAC_ADDR_W;

  logic              cyc_q;
  logic              we_q;
  logic [ADDR_W-1:0] adr_q;
  logic [DATA_W-1:0] dat_q;
  logic              launch;

  // The request is still held in the cycle_done cycle, so skip it there
  assign launch = ~cyc_q & ~cycle_done & (req.op != OP_NONE);

  assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      cyc_q      <= 1'b0;
      cycle_done <= 1'b0;
    end else begin
      cycle_done <= 1'b0;
      if (cyc_q) begin
        if (wb_i.ack) begin
          cyc_q      <= 1'b0; // Drop cyc/stb after the acked edge
          cycle_done <= 1'b1;
        end
      end else if (launch) begin
        cyc_q <= 1'b1;
      end
    end
  end

  // Bus payload frozen for the whole cycle
  always_ff @(posedge clk) begin
    if (launch) begin
      we_q  <= (req.op == OP_WRITE);
      adr_q <= req.adr;
      dat_q <= req.dat;
    end
  end

  always_ff @(posedge clk) begin
    if (cyc_q && wb_i.ack) begin
      rd_dat <= wb_i.dat; // Valid alongside cycle_done
    end
  end

endmodule

/* cpu_sm_inputs.sv */
/*
 * Transition decoder for the CPU side state machine
 * Product terms of state, direction, enable, FIFO flags,
 * last word and bus cycle completion
 */
`timescale 1ns/1ps

module cpu_sm_inputs import dma_types_pkg::*; (
  input  cpu_state_t state,
  input  logic       dma_ena,
  input  logic       dma_dir,
  input  logic       flush,
  input  logic       cycle_done,
  input  logic       last_word,
  input  fifo_stat_t stat,
  output sm_terms_t  terms
);

  logic st_idle;
  logic st_fetch;
  logic st_fill;
  logic st_drain;
  logic st_store;
  logic rd_dir;
  logic bus_end;
  logic go_on;

  assign st_idle  = (state == S_IDLE);
  assign st_fetch = (state == S_FETCH);
  assign st_fill  = (state == S_FILL_WAIT);
  assign st_drain = (state == S_DRAIN_WAIT);
  assign st_store = (state == S_STORE);

  assign rd_dir  = ~dma_dir;                        // Memory to FIFO
  assign bus_end = (st_fetch | st_store) & cycle_done;
  assign go_on   = cycle_done & dma_ena & ~last_word; // More words to move

  // Read direction, keep a free slot for the word in flight
  assign terms.start_fetch = rd_dir & ~stat.full &
                             ((st_idle & dma_ena) |
                              (st_fill & dma_ena) |
                              (st_fetch & go_on & ~stat.one_left));

  assign terms.wait_space = rd_dir & dma_ena &
                            ((st_idle & stat.full) |
                             (st_fetch & go_on & (stat.full | stat.one_left)));

  // Write direction pops the next word as the previous store ends
  assign terms.start_store = dma_dir & ~stat.empty &
                             ((st_idle & dma_ena) |
                              (st_drain & dma_ena) |
                              (st_store & go_on));

  assign terms.wait_data = dma_dir & dma_ena & stat.empty &
                           (st_idle | (st_store & go_on & ~flush));

  assign terms.fetch_done = st_fetch & cycle_done;
  assign terms.store_done = st_store & cycle_done;

  // Count exhausted, or flush with nothing left to drain
  assign terms.finish = (bus_end & last_word) |
                        (dma_dir & flush & stat.empty &
                         (st_drain | (st_store & cycle_done)));

  // Enable dropped, only taken between bus cycles
  assign terms.abort = ~dma_ena & (st_fill | st_drain | bus_end);

endmodule

/* cpu_sm.sv */
/*
 * CPU side state machine of the DMA engine
 * State, address and word count registers, bus request issue
 * and the engine end of the FIFO
 */
`timescale 1ns/1ps
`include "sdmac_consts.svh"

module cpu_sm import dma_types_pkg::*, wb_types_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     dma_ena,
  input  logic                     dma_dir,
  input  logic                     flush,
  input  logic [`SDMAC_ADDR_W-1:0] start_adr,
  input  logic [`SDMAC_CNT_W-1:0]  word_cnt,
  input  fifo_stat_t               stat,
  input  logic                     cycle_done,
  input  logic [`SDMAC_DATA_W-1:0] rd_dat,
  output periph_push_t             fifo_push,
  output logic                     fifo_pop_ready,
  input  periph_pop_t              fifo_pop,
  output bus_req_t                 req,
  output logic                     busy,
  output logic                     done
);

  localparam int DATA_W = `SDMAC_DATA_W;
  localparam int ADDR_W = `SDMAC_ADDR_W;
  localparam int CNT_W  = `SDMAC_CNT_W;
  localparam logic [ADDR_W-1:0] ADR_STEP = ADDR_W'(DATA_W / 8); // Bytes per word

  cpu_state_t        state;
  cpu_state_t        state_nxt;
  sm_terms_t         terms;
  bus_op_t           op_q;
  logic [ADDR_W-1:0] adr_q;
  logic [DATA_W-1:0] dat_q;
  logic [CNT_W-1:0]  rem_q;
  logic              flush_q;
  logic              last_word;
  logic              start;

  assign start     = (state == S_IDLE) & dma_ena;
  assign last_word = (rem_q == CNT_W'(1)); // Word in flight is the final one

  cpu_sm_inputs i_cpu_sm_inputs (
    .state      (state),
    .dma_ena    (dma_ena),
    .dma_dir    (dma_dir),
    .flush      (flush | flush_q),
    .cycle_done (cycle_done),
    .last_word  (last_word),
    .stat       (stat),
    .terms      (terms)
  );

  always_comb begin
    state_nxt = state;
    if (terms.finish || terms.abort) begin
      state_nxt = S_DONE;
    end else if (terms.start_fetch) begin
      state_nxt = S_FETCH;
    end else if (terms.start_store) begin
      state_nxt = S_STORE;
    end else if (terms.wait_space) begin
      state_nxt = S_FILL_WAIT;
    end else if (terms.wait_data) begin
      state_nxt = S_DRAIN_WAIT;
    end else if (state == S_DONE) begin
      state_nxt = S_IDLE; // One cycle done pulse
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      op_q    <= OP_NONE;
      rem_q   <= '0;
      flush_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (terms.finish || terms.abort) begin
        op_q <= OP_NONE;
      end else if (terms.start_fetch) begin
        op_q <= OP_READ;
      end else if (terms.start_store) begin
        op_q <= OP_WRITE;
      end else if (cycle_done) begin
        op_q <= OP_NONE;
      end
      if (start) begin
        rem_q <= word_cnt;
      end else if (terms.fetch_done || terms.store_done) begin
        rem_q <= rem_q - 1'b1;
      end
      // Hold a flush pulse until the transfer ends
      if (state == S_IDLE) begin
        flush_q <= 1'b0;
      end else if (flush) begin
        flush_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      adr_q <= start_adr;
    end else if (terms.fetch_done || terms.store_done) begin
      adr_q <= adr_q + ADR_STEP;
    end
    if (fifo_pop_ready && fifo_pop.valid) begin
      dat_q <= fifo_pop.data; // Store data for the next write cycle
    end
  end

  assign req = '{op: op_q, adr: adr_q, dat: dat_q};

  assign fifo_push      = '{valid: terms.fetch_done, data: rd_dat};
  assign fifo_pop_ready = terms.start_store;

  assign busy = (state != S_IDLE) && (state != S_DONE);
  assign done = (state == S_DONE);

endmodule

/* sdmac_dma_top.sv */
/*
 * DMA engine top level
 * FIFO, Wishbone master and CPU side state machine,
 * plus the direction mux of the FIFO ends
 */
`timescale 1ns/1ps
`include "sdmac_consts.svh"

module sdmac_dma_top import dma_types_pkg::*, wb_types_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     dma_ena,
  input  logic                     dma_dir,
  input  logic                     flush,
  input  logic [`SDMAC_ADDR_W-1:0] start_adr,
  input  logic [`SDMAC_CNT_W-1:0]  word_cnt,
  input  periph_push_t             periph_push,
  output logic                     push_ready,
  output periph_pop_t              periph_pop,
  input  logic                     pop_ready,
  output wb_m2s_t                  wb_o,
  input  wb_s2m_t                  wb_i,
  output logic                     busy,
  output logic                     done
);

  fifo_stat_t               stat;
  periph_push_t             eng_push;
  periph_push_t             fifo_push;
  periph_pop_t              fifo_pop;
  logic                     eng_pop_ready;
  logic                     fifo_pop_ready;
  bus_req_t                 req;
  logic                     cycle_done;
  logic [`SDMAC_DATA_W-1:0] rd_dat;

  // Peripheral fills in the write direction, engine fills in the read direction
  assign fifo_push      = dma_dir ? periph_push : eng_push;
  assign fifo_pop_ready = dma_dir ? eng_pop_ready : pop_ready;
  assign periph_pop     = '{valid: fifo_pop.valid & ~dma_dir, data: fifo_pop.data};

  dma_fifo i_dma_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (fifo_push),
    .push_ready (push_ready), // Only honoured when dma_dir is high
    .pop        (fifo_pop),
    .pop_ready  (fifo_pop_ready),
    .stat       (stat)
  );

  wb_master i_wb_master (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .wb_o       (wb_o),
    .wb_i       (wb_i),
    .cycle_done (cycle_done),
    .rd_dat     (rd_dat)
  );

  cpu_sm i_cpu_sm (
    .clk            (clk),
    .rst            (rst),
    .dma_ena        (dma_ena),
    .dma_dir        (dma_dir),
    .flush          (flush),
    .start_adr      (start_adr),
    .word_cnt       (word_cnt),
    .stat           (stat),
    .cycle_done     (cycle_done),
    .rd_dat         (rd_dat),
    .fifo_push      (eng_push),
    .fifo_pop_ready (eng_pop_ready),
    .fifo_pop       (fifo_pop),
    .req            (req),
    .busy           (busy),
    .done           (done)
  );

endmodule

/* tb_sdmac_dma.sv */
/*
 * Directed testbench for the DMA engine top level
 * Wishbone memory model with random ack delay, peripheral drivers,
 * reset, read, write, back-pressure and flush tests
 */
`timescale 1ns/1ps
`include "sdmac_consts.svh"

module tb_sdmac_dma import dma_types_pkg::*, wb_types_pkg::*; ();

  localparam int DEPTH           = `SDMAC_FIFO_DEPTH;
  localparam int CYCLES_PER_WORD = 12; // Launch, 3 wait states, ack, done, reissue, slack
  localparam int STALL_HOLD      = 30;
  localparam int WORDS_TOTAL     = 5 + 6 + 12 + 10;
  localparam int WATCHDOG_CYCLES = WORDS_TOTAL * CYCLES_PER_WORD + STALL_HOLD + 300;
  localparam logic [31:0] RD_PATTERN = 32'h5A3C_96E1;

  logic                     clk;
  logic                     rst;
  logic                     dma_ena;
  logic                     dma_dir;
  logic                     flush;
  logic                     pop_ready;
  logic                     push_ready;
  logic                     busy;
  logic                     done;
  logic [`SDMAC_ADDR_W-1:0] start_adr;
  logic [`SDMAC_CNT_W-1:0]  word_cnt;
  periph_push_t             periph_push;
  periph_pop_t              periph_pop;
  wb_m2s_t                  wb_o;
  wb_s2m_t                  wb_i;

  logic [31:0] mem_seed;
  logic [1:0]  mem_wait;     // Wait states left before ack
  int          acked_cnt;
  logic [31:0] wr_adr_log[$];
  logic [31:0] wr_dat_log[$];
  logic [31:0] data_seed;    // Peripheral write data stream
  int          check_cnt;
  int          mismatch_cnt;
  int          other_err_cnt;

  sdmac_dma_top i_sdmac_dma_top (
    .clk         (clk),
    .rst         (rst),
    .dma_ena     (dma_ena),
    .dma_dir     (dma_dir),
    .flush       (flush),
    .start_adr   (start_adr),
    .word_cnt    (word_cnt),
    .periph_push (periph_push),
    .push_ready  (push_ready),
    .periph_pop  (periph_pop),
    .pop_ready   (pop_ready),
    .wb_o        (wb_o),
    .wb_i        (wb_i),
    .busy        (busy),
    .done        (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory read data depends only on the byte address
  function automatic logic [31:0] read_rule(input logic [31:0] adr);
    return adr ^ RD_PATTERN;
  endfunction

  // Wishbone slave memory with ack registered after 0 to 3 wait cycles
  initial begin
    wb_i = '{ack: 1'b0, dat: '0};
    forever begin
      @(posedge clk);
      if (rst) begin
        wb_i      <= '{ack: 1'b0, dat: '0};
        mem_seed  <= 32'd92;
        mem_wait  <= 2'd0;
        acked_cnt <= 0;
      end else if (wb_o.cyc && wb_o.stb) begin
        if (wb_i.ack) begin
          wb_i.ack  <= 1'b0; // Master drops cyc after this edge
          acked_cnt <= acked_cnt + 1;
          mem_seed  <= lcg_next(mem_seed);
          mem_wait  <= mem_seed[17:16];
          check_value("wb_o.we", 32'(wb_o.we), 32'(dma_dir)); // High only for writes
          if (wb_o.we) begin
            wr_adr_log.push_back(wb_o.adr);
            wr_dat_log.push_back(wb_o.dat);
          end
        end else if (mem_wait == 2'd0) begin
          wb_i <= '{ack: 1'b1, dat: read_rule(wb_o.adr)};
        end else begin
          mem_wait <= mem_wait - 2'd1;
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    other_err_cnt++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic start_transfer(input logic dir, input logic [31:0] adr,
                                input logic [`SDMAC_CNT_W-1:0] cnt);
    @(posedge clk);
    dma_dir   <= dir;
    start_adr <= adr;
    word_cnt  <= cnt;
    dma_ena   <= 1'b1;
  endtask

  // Done must not pulse again and busy must stay low once back in idle
  task automatic close_transfer(input string name);
    repeat (3) begin
      @(posedge clk);
      if (done) report_error({name, ": done pulsed more than once"});
    end
    check_value("busy", 32'(busy), 32'd0);
  endtask

  task automatic collect_reads(input logic [31:0] base, input int n, input int limit);
    int got;
    int cycles;
    bit seen_done;
    got       = 0;
    cycles    = 0;
    seen_done = 1'b0;
    while ((!seen_done || got < n) && cycles < limit) begin
      @(posedge clk);
      cycles++;
      if (periph_pop.valid && pop_ready) begin
        check_value("periph_pop.data", periph_pop.data, read_rule(base + 32'(4 * got)));
        got++;
      end
      if (done) begin
        if (seen_done) report_error("read transfer: done pulsed twice");
        seen_done = 1'b1;
        dma_ena   <= 1'b0; // Drop before the engine sees idle again
      end
    end
    if (!seen_done) report_error("read transfer never reached done");
    check_value("popped word count", 32'(got), 32'(n));
  endtask

  task automatic push_and_wait(input logic [31:0] words[$], input bit flush_after,
                               input int limit);
    int pushed;
    int cycles;
    bit seen_done;
    pushed    = 0;
    cycles    = 0;
    seen_done = 1'b0;
    periph_push <= '{valid: 1'b1, data: words[0]};
    while (!seen_done && cycles < limit) begin
      @(posedge clk);
      cycles++;
      if (periph_push.valid && push_ready) begin
        pushed++;
        if (pushed < words.size()) begin
          periph_push <= '{valid: 1'b1, data: words[pushed]};
        end else begin
          periph_push <= '{valid: 1'b0, data: '0};
          flush       <= flush_after; // No more words follow
        end
      end
      if (done) begin
        seen_done = 1'b1;
        dma_ena   <= 1'b0;
        flush     <= 1'b0;
      end
    end
    if (!seen_done) report_error("write transfer never reached done");
    check_value("pushed word count", 32'(pushed), 32'(words.size()));
  endtask

  task automatic check_write_log(input logic [31:0] base, input logic [31:0] words[$],
                                 input int first);
    int i;
    check_value("logged write count", 32'(wr_adr_log.size() - first), 32'(words.size()));
    for (i = 0; i < words.size() && first + i < wr_adr_log.size(); i++) begin
      check_value("wb_o.adr", wr_adr_log[first + i], base + 32'(4 * i));
      check_value("wb_o.dat", wr_dat_log[first + i], words[i]);
    end
  endtask

  task automatic test_reset_values();
    @(posedge clk);
    check_value("wb_o.cyc", 32'(wb_o.cyc), 32'd0);
    check_value("wb_o.stb", 32'(wb_o.stb), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    check_value("done", 32'(done), 32'd0);
    check_value("periph_pop.valid", 32'(periph_pop.valid), 32'd0);
    check_value("push_ready", 32'(push_ready), 32'd1);
  endtask

  task automatic test_read_basic();
    logic [31:0] base;
    base = 32'h0000_1000;
    start_transfer(1'b0, base, 16'd5);
    pop_ready <= 1'b1;
    collect_reads(base, 5, 5 * CYCLES_PER_WORD + 20);
    close_transfer("read");
  endtask

  task automatic test_write_basic();
    logic [31:0] base;
    logic [31:0] words[$];
    int          first;
    base  = 32'h0000_2000;
    first = wr_adr_log.size();
    repeat (6) begin
      data_seed = lcg_next(data_seed);
      words.push_back(data_seed);
    end
    start_transfer(1'b1, base, 16'd6);
    push_and_wait(words, 1'b0, 6 * CYCLES_PER_WORD + 20);
    close_transfer("write");
    check_write_log(base, words, first);
  endtask

  task automatic test_read_backpressure();
    logic [31:0] base;
    int          acked_base;
    int          cycles;
    base       = 32'h0000_3000;
    acked_base = acked_cnt;
    cycles     = 0;
    start_transfer(1'b0, base, 16'd12);
    pop_ready <= 1'b0;
    while (acked_cnt - acked_base < DEPTH && cycles < DEPTH * CYCLES_PER_WORD + 20) begin
      @(posedge clk);
      cycles++;
      if (done) report_error("back-pressure read ended while the FIFO was filling");
    end
    if (acked_cnt - acked_base < DEPTH) report_error("FIFO never filled during stalled read");
    repeat (STALL_HOLD) @(posedge clk); // Bus stays idle while the FIFO is full
    check_value("acked cycles", 32'(acked_cnt - acked_base), 32'(DEPTH));
    check_value("wb_o.cyc", 32'(wb_o.cyc), 32'd0);
    check_value("busy", 32'(busy), 32'd1);
    pop_ready <= 1'b1;
    collect_reads(base, 12, 12 * CYCLES_PER_WORD + 20);
    close_transfer("back-pressure read");
  endtask

  task automatic test_write_flush();
    logic [31:0] base;
    logic [31:0] words[$];
    int          first;
    base  = 32'h0000_4000;
    first = wr_adr_log.size();
    repeat (4) begin
      data_seed = lcg_next(data_seed);
      words.push_back(data_seed);
    end
    start_transfer(1'b1, base, 16'd10); // Count larger than the words supplied
    push_and_wait(words, 1'b1, 10 * CYCLES_PER_WORD + 20);
    close_transfer("flush write");
    check_write_log(base, words, first);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Error: watchdog expired after %0d cycles, DUT stopped responding",
             WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst           = 1'b1;
    dma_ena       = 1'b0;
    dma_dir       = 1'b0;
    flush         = 1'b0;
    pop_ready     = 1'b0;
    start_adr     = '0;
    word_cnt      = '0;
    periph_push   = '{valid: 1'b0, data: '0};
    data_seed     = 32'd92;
    check_cnt     = 0;
    mismatch_cnt  = 0;
    other_err_cnt = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_reset_values();
    test_read_basic();
    test_write_basic();
    test_read_backpressure();
    test_write_flush();
    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             check_cnt, mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
dma_types_pkg.sv
wb_types_pkg.sv
dma_fifo.sv
wb_master.sv
cpu_sm_inputs.sv
cpu_sm.sv
sdmac_dma_top.sv
tb_sdmac_dma.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sdmac_dma -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
